/* Makefile */
TOP = cpu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

/* all.f */
source/cpu_pkg.sv
source/alu.sv
source/branch_unit.sv
source/register_file.sv
source/forwarding_unit.sv
source/word_ram.sv
source/cpu_core.sv
source/cpu_top.sv
dv/clk_gen.sv
dv/cpu_asserts.sv
dv/cpu_tb.sv

/* dv/clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
) (
	input  logic hold,
	output logic Clk,
	output logic rst_n
);

	logic clk_q = 1'b0;
	logic rst_q = 1'b0;
	int   count = 0;

	always #(PERIOD / 2) clk_q = ~clk_q;

	// Reset stays low for the first cycles and while held for loading
	always @(posedge clk_q) begin
		if (count < RESET_CYCLES) begin
			count <= count + 1;
		end
		rst_q <= !hold && count >= RESET_CYCLES - 1;
	end

	assign Clk = clk_q;
	assign rst_n = rst_q;

endmodule

`default_nettype wire

/* dv/cpu_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_asserts
	import cpu_pkg::*;
(
	input logic  Clk,
	input logic  rst_n,
	input logic  dmem_we,
	input logic  out_valid,
	input logic  halted,
	input word_t num_inst
);

	// Quiet outputs once reset has been seen for a full cycle
	quiet_in_reset: assert property (
		@(posedge Clk) (!rst_n && !$past(rst_n)) |-> (!dmem_we && !out_valid)
	) else $error("dmem_we or out_valid high while reset is held");

	halted_sticky: assert property (
		@(posedge Clk) $fell(halted) |-> !$past(rst_n)
	) else $error("halted fell without a reset");

	count_monotonic: assert property (
		@(posedge Clk) $past(rst_n) |-> (num_inst >= $past(num_inst))
	) else $error("num_inst decreased outside reset");

endmodule

bind cpu_core cpu_asserts i_cpu_asserts (
	.Clk       (Clk),
	.rst_n     (rst_n),
	.dmem_we   (dmem_we),
	.out_valid (out_valid),
	.halted    (halted),
	.num_inst  (num_inst)
);

`default_nettype wire

/* dv/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_tb
	import cpu_pkg::*;
();

	localparam int IMEM_ADDR_W = 8;
	localparam int DMEM_ADDR_W = 8;
	localparam int DMEM_WORDS = 2 ** DMEM_ADDR_W;
	localparam int NUM_PROGS = 4;
	localparam int PROG_LEN = 48;
	localparam int MODEL_STEP_LIMIT = 4096;
	// Fill loop takes five cycles per word, plus loading and drain
	localparam int FILL_CYCLES = DMEM_WORDS * 6 + 40;
	localparam int MAX_CYCLES = FILL_CYCLES + NUM_PROGS * (PROG_LEN + PROG_LEN * 4 + 20);

	logic  Clk;
	logic  rst_n;
	logic  hold_reset;
	logic  load_valid;
	word_t load_addr;
	word_t load_data;
	logic  out_valid;
	word_t out_data;
	logic  halted;
	word_t num_inst;

	logic [31:0] rng_state = 32'h2a1b;
	int          cycle_count = 0;
	word_t       prog [PROG_LEN];
	int          prog_len;
	word_t       model_mem [DMEM_WORDS];
	word_t       expected_out [$];
	int          model_count;

	clk_gen i_clk_gen (
		.hold  (hold_reset),
		.Clk   (Clk),
		.rst_n (rst_n)
	);

	cpu_top #(
		.IMEM_ADDR_W (IMEM_ADDR_W),
		.DMEM_ADDR_W (DMEM_ADDR_W)
	) i_cpu_top (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.load_valid (load_valid),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.halted     (halted),
		.num_inst   (num_inst)
	);

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		rng_state = xorshift32(rng_state);
		return rng_state % n;
	endfunction

	function automatic word_t encode_itype(opcode_e op, reg_idx_t rs, reg_idx_t rt,
		logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encode_rtype(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, func_e fn);
		return {OP_RTYPE, rs, rt, rd, fn};
	endfunction

	// Writes each data word with its own address
	task automatic build_fill_program();
		prog[0] = encode_itype(OP_LHI, 2'd0, 2'd2, 8'(DMEM_WORDS >> 8));
		prog[1] = encode_itype(OP_SWD, 2'd1, 2'd1, 8'h00);
		prog[2] = encode_itype(OP_ADI, 2'd1, 2'd1, 8'h01);
		prog[3] = encode_itype(OP_BNE, 2'd1, 2'd2, 8'hfd);
		prog[4] = encode_rtype(2'd0, 2'd0, 2'd0, FN_HLT);
		prog_len = 5;
	endtask

	task automatic gen_program();
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [7:0] imm;
		int         kind;
		int         span;
		int         skip;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			rs = reg_idx_t'(rand_below(4));
			rt = reg_idx_t'(rand_below(4));
			rd = reg_idx_t'(rand_below(4));
			imm = 8'(rand_below(256));
			kind = int'(rand_below(16));
			// Forward targets only, never past the final HLT
			span = (PROG_LEN - 1 - i < 5) ? PROG_LEN - 1 - i : 5;
			skip = int'(rand_below(span));
			case (kind)
				0, 1: prog[i] = encode_itype(OP_ADI, rs, rt, imm);
				2: prog[i] = encode_itype(OP_LHI, rs, rt, imm);
				3, 4: prog[i] = encode_itype(OP_LWD, rs, rt, imm);
				5: prog[i] = encode_itype(OP_SWD, rs, rt, imm);
				6: prog[i] = encode_rtype(rs, rt, rd, FN_ADD);
				7: prog[i] = encode_rtype(rs, rt, rd, FN_SUB);
				8: prog[i] = encode_rtype(rs, rt, rd, FN_AND);
				9: prog[i] = encode_rtype(rs, rt, rd, FN_ORR);
				10, 11, 12: prog[i] = encode_rtype(rs, rt, rd, FN_WWD);
				13: prog[i] = encode_itype(OP_BNE, rs, rt, 8'(skip));
				14: prog[i] = encode_itype(OP_BEQ, rs, rt, 8'(skip));
				default: prog[i] = {OP_JMP, 12'(i + 1 + skip)};
			endcase
		end
		prog[PROG_LEN - 1] = encode_rtype(2'd0, 2'd0, 2'd0, FN_HLT);
		prog_len = PROG_LEN;
	endtask

	// ISA-level execution of prog, one instruction per step
	task automatic run_model();
		word_t regs [4];
		word_t instr;
		word_t a;
		word_t b;
		word_t imm;
		word_t addr;
		int    pc;
		int    next_pc;
		int    steps;
		logic  done;
		for (int i = 0; i < 4; i++) begin
			regs[i] = '0;
		end
		expected_out.delete();
		model_count = 0;
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < MODEL_STEP_LIMIT && pc < prog_len) begin
			instr = prog[pc];
			a = regs[instr[11:10]];
			b = regs[instr[9:8]];
			imm = {{8{instr[7]}}, instr[7:0]};
			addr = a + imm;
			next_pc = pc + 1;
			case (opcode_e'(instr[15:12]))
				OP_ADI: regs[instr[9:8]] = a + imm;
				OP_LHI: regs[instr[9:8]] = {instr[7:0], 8'h00};
				OP_LWD: regs[instr[9:8]] = model_mem[addr[DMEM_ADDR_W-1:0]];
				OP_SWD: model_mem[addr[DMEM_ADDR_W-1:0]] = b;
				OP_BNE: if (a != b) next_pc = pc + 1 + int'($signed(instr[7:0]));
				OP_BEQ: if (a == b) next_pc = pc + 1 + int'($signed(instr[7:0]));
				OP_JMP: next_pc = int'(instr[11:0]);
				OP_RTYPE: begin
					case (func_e'(instr[5:0]))
						FN_ADD: regs[instr[7:6]] = a + b;
						FN_SUB: regs[instr[7:6]] = a - b;
						FN_AND: regs[instr[7:6]] = a & b;
						FN_ORR: regs[instr[7:6]] = a | b;
						FN_WWD: expected_out.push_back(a);
						FN_HLT: done = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			model_count++;
			steps++;
			pc = next_pc;
		end
		assert (done) else report_fail("reference model never reached HLT");
	endtask

	task automatic run_test(input string name);
		int got;
		run_model();
		@(posedge Clk);
		hold_reset <= 1'b1;
		while (rst_n) @(posedge Clk);
		for (int i = 0; i < prog_len; i++) begin
			load_valid <= 1'b1;
			load_addr <= word_t'(i);
			load_data <= prog[i];
			@(posedge Clk);
		end
		load_valid <= 1'b0;
		hold_reset <= 1'b0;

		@(negedge Clk);
		while (!rst_n) @(negedge Clk);
		assert (num_inst == '0) else report_fail($sformatf(
			"mismatch %s num_inst after reset expected 0 actual %0d", name, num_inst));
		assert (!halted) else report_fail($sformatf("%s: halted still high after reset", name));

		got = 0;
		while (!halted) begin
			if (out_valid) begin
				assert (got < expected_out.size()) else report_fail($sformatf(
					"%s: more WWD outputs than the model produced (%0d)", name,
					expected_out.size()));
				assert (out_data == expected_out[got]) else report_fail($sformatf(
					"mismatch %s wwd %0d expected %h actual %h", name, got,
					expected_out[got], out_data));
				got++;
			end
			@(negedge Clk);
		end

		assert (got == expected_out.size()) else report_fail($sformatf(
			"mismatch %s wwd count expected %0d actual %0d", name, expected_out.size(), got));
		assert (num_inst == word_t'(model_count)) else report_fail($sformatf(
			"mismatch %s num_inst expected %0d actual %0d", name, model_count, num_inst));
		// Starts with the cycle in which halted first shows
		repeat (4) begin
			assert (!out_valid) else report_fail($sformatf("%s: WWD output after halt", name));
			assert (halted) else report_fail($sformatf("%s: halted dropped without reset", name));
			@(negedge Clk);
		end
	endtask

	always @(posedge Clk) begin
		cycle_count <= cycle_count + 1;
		assert (cycle_count < MAX_CYCLES) else report_fail("timeout waiting for halt");
	end

	initial begin
		hold_reset = 1'b1;
		load_valid = 1'b0;
		load_addr = '0;
		load_data = '0;
		for (int i = 0; i < DMEM_WORDS; i++) begin
			model_mem[i] = '0;
		end
		// Known data RAM contents before the random programs
		build_fill_program();
		run_test("dmem_fill");
		for (int p = 0; p < NUM_PROGS; p++) begin
			gen_program();
			run_test($sformatf("prog%0d", p));
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input  word_t   a,
	input  word_t   b,
	input  alu_op_e op,
	output word_t   result
);

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_AND:    result = a & b;
			ALU_OR:     result = a | b;
			ALU_PASS_B: result = b;
			// Immediate lands in the upper byte
			ALU_LHI:    result = {b[7:0], 8'h00};
			default:    result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit
	import cpu_pkg::*;
(
	input  ctrl_t   ctrl,
	input  opcode_e opcode,
	input  word_t   a,
	input  word_t   b,
	input  word_t   pc,
	input  word_t   imm,
	output logic    take,
	output word_t   target
);

	logic cond;

	always_comb begin
		case (opcode)
			OP_BEQ:  cond = (a == b);
			OP_BNE:  cond = (a != b);
			default: cond = 1'b0;
		endcase
	end

	assign take = ctrl.is_jump | (ctrl.is_branch & cond);

	// Jumps stay inside the current 4K page
	assign target = ctrl.is_jump ? {pc[15:12], imm[11:0]} : pc + 16'd1 + imm;

endmodule

`default_nettype wire

/* source/cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core
	import cpu_pkg::*;
#(
	parameter int IMEM_ADDR_W = 8,
	parameter int DMEM_ADDR_W = 8
) (
	input  logic                   Clk,
	input  logic                   rst_n,
	output logic [IMEM_ADDR_W-1:0] imem_addr,
	input  word_t                  imem_data,
	output logic [DMEM_ADDR_W-1:0] dmem_addr,
	output word_t                  dmem_wdata,
	output logic                   dmem_we,
	input  word_t                  dmem_rdata,
	output logic                   out_valid,
	output word_t                  out_data,
	output logic                   halted,
	output word_t                  num_inst
);

	word_t    pc;
	logic     if_id_valid;
	word_t    if_id_instr;
	word_t    if_id_pc;
	id_ex_t   id_ex;
	id_ex_t   id_ex_d;
	ex_mem_t  ex_mem;
	ex_mem_t  ex_mem_d;
	mem_wb_t  mem_wb;
	mem_wb_t  mem_wb_d;
	ctrl_t    dec_ctrl;
	reg_idx_t dec_dest;
	word_t    rdata1;
	word_t    rdata2;
	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	logic     load_stall;
	word_t    op_a;
	word_t    op_b;
	word_t    alu_result;
	word_t    br_target;
	logic     take;
	logic     flush;
	logic     halt_seen;

	register_file i_register_file (
		.Clk    (Clk),
		.rst_n  (rst_n),
		.raddr1 (instr_rs(if_id_instr)),
		.raddr2 (instr_rt(if_id_instr)),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (mem_wb.ctrl.reg_write),
		.waddr  (mem_wb.dest),
		.wdata  (mem_wb.result)
	);

	// Decode
	always_comb begin
		dec_ctrl = '0;
		dec_ctrl.alu_op = ALU_PASS_B;
		dec_dest = instr_rt(if_id_instr);
		case (instr_opcode(if_id_instr))
			OP_ADI: begin
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.alu_op = ALU_ADD;
				dec_ctrl.use_imm = 1'b1;
			end
			OP_LHI: begin
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.alu_op = ALU_LHI;
				dec_ctrl.use_imm = 1'b1;
			end
			OP_LWD: begin
				dec_ctrl.reg_write = 1'b1;
				dec_ctrl.mem_read = 1'b1;
				dec_ctrl.alu_op = ALU_ADD;
				dec_ctrl.use_imm = 1'b1;
			end
			OP_SWD: begin
				dec_ctrl.mem_write = 1'b1;
				dec_ctrl.alu_op = ALU_ADD;
				dec_ctrl.use_imm = 1'b1;
			end
			OP_BNE, OP_BEQ: dec_ctrl.is_branch = 1'b1;
			OP_JMP: dec_ctrl.is_jump = 1'b1;
			OP_RTYPE: begin
				dec_dest = instr_rd(if_id_instr);
				case (instr_func(if_id_instr))
					FN_ADD: {dec_ctrl.reg_write, dec_ctrl.alu_op} = {1'b1, ALU_ADD};
					FN_SUB: {dec_ctrl.reg_write, dec_ctrl.alu_op} = {1'b1, ALU_SUB};
					FN_AND: {dec_ctrl.reg_write, dec_ctrl.alu_op} = {1'b1, ALU_AND};
					FN_ORR: {dec_ctrl.reg_write, dec_ctrl.alu_op} = {1'b1, ALU_OR};
					FN_WWD: dec_ctrl.is_wwd = 1'b1;
					FN_HLT: dec_ctrl.is_halt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
		if (!if_id_valid) begin
			dec_ctrl = '0;
		end
	end

	always_comb begin
		id_ex_d.ctrl = dec_ctrl;
		if (load_stall || flush) begin
			id_ex_d.ctrl = '0;
		end
		id_ex_d.pc = if_id_pc;
		id_ex_d.rs = instr_rs(if_id_instr);
		id_ex_d.rt = instr_rt(if_id_instr);
		id_ex_d.dest = dec_dest;
		id_ex_d.rdata1 = rdata1;
		id_ex_d.rdata2 = rdata2;
		id_ex_d.imm = dec_ctrl.is_jump ? instr_jfield(if_id_instr) : instr_imm8(if_id_instr);
		id_ex_d.opcode = instr_opcode(if_id_instr);
	end

	forwarding_unit i_forwarding_unit (
		.id_ex      (id_ex),
		.ex_mem     (ex_mem),
		.mem_wb     (mem_wb),
		.if_id_rs   (instr_rs(if_id_instr)),
		.if_id_rt   (instr_rt(if_id_instr)),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b),
		.load_stall (load_stall)
	);

	always_comb begin
		case (fwd_a)
			FWD_MEM: op_a = ex_mem.result;
			FWD_WB:  op_a = mem_wb.result;
			default: op_a = id_ex.rdata1;
		endcase
		case (fwd_b)
			FWD_MEM: op_b = ex_mem.result;
			FWD_WB:  op_b = mem_wb.result;
			default: op_b = id_ex.rdata2;
		endcase
	end

	alu i_alu (
		.a      (op_a),
		.b      (id_ex.ctrl.use_imm ? id_ex.imm : op_b),
		.op     (id_ex.ctrl.alu_op),
		.result (alu_result)
	);

	branch_unit i_branch_unit (
		.ctrl   (id_ex.ctrl),
		.opcode (id_ex.opcode),
		.a      (op_a),
		.b      (op_b),
		.pc     (id_ex.pc),
		.imm    (id_ex.imm),
		.take   (take),
		.target (br_target)
	);

	// Redirect or halt kills the two younger stages
	assign flush = take | id_ex.ctrl.is_halt;

	always_comb begin
		ex_mem_d.ctrl = id_ex.ctrl;
		ex_mem_d.dest = id_ex.dest;
		ex_mem_d.result = alu_result;
		// WWD carries rs to the output port
		ex_mem_d.store_data = id_ex.ctrl.is_wwd ? op_a : op_b;
	end

	always_comb begin
		mem_wb_d.ctrl = ex_mem.ctrl;
		mem_wb_d.dest = ex_mem.dest;
		mem_wb_d.result = ex_mem.ctrl.mem_read ? dmem_rdata : ex_mem.result;
	end

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			pc <= '0;
			if_id_valid <= 1'b0;
			id_ex.ctrl <= '0;
			ex_mem.ctrl <= '0;
			mem_wb.ctrl <= '0;
			halt_seen <= 1'b0;
			halted <= 1'b0;
			num_inst <= '0;
		end else begin
			if (take) begin
				pc <= br_target;
			end else if (!load_stall && !halt_seen && !id_ex.ctrl.is_halt) begin
				pc <= pc + 16'd1;
			end
			if (flush || halt_seen) begin
				if_id_valid <= 1'b0;
			end else if (!load_stall) begin
				if_id_valid <= 1'b1;
				if_id_instr <= imem_data;
				if_id_pc <= pc;
			end
			id_ex <= id_ex_d;
			ex_mem <= ex_mem_d;
			mem_wb <= mem_wb_d;
			halt_seen <= halt_seen | id_ex.ctrl.is_halt;
			halted <= halted | mem_wb.ctrl.is_halt;
			// Every real instruction sets at least one control bit
			if (mem_wb.ctrl != '0) begin
				num_inst <= num_inst + 16'd1;
			end
		end
	end

	assign imem_addr = pc[IMEM_ADDR_W-1:0];
	assign dmem_addr = ex_mem.result[DMEM_ADDR_W-1:0];
	assign dmem_wdata = ex_mem.store_data;
	assign dmem_we = ex_mem.ctrl.mem_write;
	assign out_valid = ex_mem.ctrl.is_wwd;
	assign out_data = ex_mem.store_data;

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0] reg_idx_t;

	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_ADI   = 4'd4,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASS_B,
		ALU_LHI
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    is_wwd;
		logic    is_halt;
		logic    is_branch;
		logic    is_jump;
		alu_op_e alu_op;
		logic    use_imm;
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    pc;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dest;
		word_t    rdata1;
		word_t    rdata2;
		word_t    imm;
		opcode_e  opcode;
	} id_ex_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t dest;
		word_t    result;
		word_t    store_data;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t dest;
		word_t    result;
	} mem_wb_t;

	function automatic opcode_e instr_opcode(word_t instr);
		return opcode_e'(instr[15:12]);
	endfunction

	function automatic reg_idx_t instr_rs(word_t instr);
		return instr[11:10];
	endfunction

	function automatic reg_idx_t instr_rt(word_t instr);
		return instr[9:8];
	endfunction

	function automatic reg_idx_t instr_rd(word_t instr);
		return instr[7:6];
	endfunction

	function automatic func_e instr_func(word_t instr);
		return func_e'(instr[5:0]);
	endfunction

	function automatic word_t instr_imm8(word_t instr);
		return {{8{instr[7]}}, instr[7:0]};
	endfunction

	// Jump field, upper PC bits are joined in execute
	function automatic word_t instr_jfield(word_t instr);
		return {4'h0, instr[11:0]};
	endfunction

endpackage

`default_nettype wire

/* source/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top
	import cpu_pkg::*;
#(
	parameter int IMEM_ADDR_W = 8,
	parameter int DMEM_ADDR_W = 8
) (
	input  logic  Clk,
	input  logic  rst_n,
	input  logic  load_valid,
	input  word_t load_addr,
	input  word_t load_data,
	output logic  out_valid,
	output word_t out_data,
	output logic  halted,
	output word_t num_inst
);

	logic [IMEM_ADDR_W-1:0] imem_addr;
	word_t                  imem_data;
	logic [DMEM_ADDR_W-1:0] dmem_addr;
	word_t                  dmem_wdata;
	logic                   dmem_we;
	word_t                  dmem_rdata;

	cpu_core #(
		.IMEM_ADDR_W (IMEM_ADDR_W),
		.DMEM_ADDR_W (DMEM_ADDR_W)
	) i_cpu_core (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.halted     (halted),
		.num_inst   (num_inst)
	);

	// Program is written through the load strobe only
	word_ram #(
		.ADDR_W (IMEM_ADDR_W)
	) i_imem (
		.Clk   (Clk),
		.we    (load_valid),
		.waddr (load_addr[IMEM_ADDR_W-1:0]),
		.raddr (imem_addr),
		.wdata (load_data),
		.rdata (imem_data)
	);

	word_ram #(
		.ADDR_W (DMEM_ADDR_W)
	) i_dmem (
		.Clk   (Clk),
		.we    (dmem_we),
		.waddr (dmem_addr),
		.raddr (dmem_addr),
		.wdata (dmem_wdata),
		.rdata (dmem_rdata)
	);

endmodule

`default_nettype wire

/* source/forwarding_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module forwarding_unit
	import cpu_pkg::*;
(
	input  id_ex_t   id_ex,
	input  ex_mem_t  ex_mem,
	input  mem_wb_t  mem_wb,
	input  reg_idx_t if_id_rs,
	input  reg_idx_t if_id_rt,
	output fwd_sel_e fwd_a,
	output fwd_sel_e fwd_b,
	output logic     load_stall
);

	// Younger result in memory stage wins
	always_comb begin
		fwd_a = FWD_REG;
		if (ex_mem.ctrl.reg_write && ex_mem.dest == id_ex.rs) begin
			fwd_a = FWD_MEM;
		end else if (mem_wb.ctrl.reg_write && mem_wb.dest == id_ex.rs) begin
			fwd_a = FWD_WB;
		end

		fwd_b = FWD_REG;
		if (ex_mem.ctrl.reg_write && ex_mem.dest == id_ex.rt) begin
			fwd_b = FWD_MEM;
		end else if (mem_wb.ctrl.reg_write && mem_wb.dest == id_ex.rt) begin
			fwd_b = FWD_WB;
		end
	end

	assign load_stall = id_ex.ctrl.mem_read &&
		(id_ex.dest == if_id_rs || id_ex.dest == if_id_rt);

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file
	import cpu_pkg::*;
(
	input  logic     Clk,
	input  logic     rst_n,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	output word_t    rdata1,
	output word_t    rdata2,
	input  logic     we,
	input  reg_idx_t waddr,
	input  word_t    wdata
);

	word_t regs [4];

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Writeback value bypasses into decode
	assign rdata1 = (we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

/* source/word_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module word_ram
	import cpu_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  logic              Clk,
	input  logic              we,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [ADDR_W-1:0] raddr,
	input  word_t             wdata,
	output word_t             rdata
);

	word_t mem [2**ADDR_W];

	always_ff @(posedge Clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr];

endmodule

`default_nettype wire
